// File: vlog.f
+incdir+hdl
hdl/hc_data_pkg.sv
hdl/hc_ctrl_pkg.sv
hdl/head_cache_queue.sv
hdl/head_cache.sv
hdl/hc_arbiter.sv
hdl/dram_block_store.sv
hdl/dram_head_cache_top.sv
sim/tb_dram_head_cache.sv

// File: sim/tb_dram_head_cache.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module tb_dram_head_cache
   import hc_data_pkg::*, hc_ctrl_pkg::*;
();

   localparam int NQ         = `HC_NUM_QUEUES;
   localparam int BLK_ENT    = `HC_BLOCK_BYTES / `HC_ENTRY_BYTES;
   localparam int SETTLE_CNT = `HC_QUEUE_DEPTH - BLK_ENT;    // grants stop here
   localparam int CHK_W      = $bits(hc_entry_t);
   localparam int NUM_ROWS   = 5;
   localparam int MAX_PKTS   = 5;
   localparam int LIMIT      = 4000;                         // cycles per wait loop
   localparam int QUIET      = 24;

   typedef struct {
      string          name;
      hc_queue_mask_t mask;
      bit             cut;          // 1 cut-through, 0 dram store
      int             lens [MAX_PKTS];
      int             prob;         // mac_tx_rdy percent
      bit             hold;         // back-pressure until settled
   } row_t;

   logic                          clk = 1'b0;
   logic                          reset;
   logic                          store_wr;
   hc_queue_t                     store_queue;
   hc_entry_t                     store_entry;
   hc_queue_mask_t                store_space;
   hc_queue_mask_t                tc_hc_wr;
   hc_entry_t [NQ-1:0]            tc_hc_entry;
   hc_queue_mask_t                hc_q_rdy;
   hc_queue_mask_t                mac_tx_rdy;
   hc_word_t [NQ-1:0]             hc_word;
   hc_queue_mask_t                hc_wr;
   hc_entry_cnt_t [NQ-1:0]        hc_q_occup_cnt;
   hc_queue_mask_t                hc_q_space_one_blk;

   row_t                          rows [NUM_ROWS];
   hc_entry_t                     ent_q [NQ][$];   // entries still to be written
   hc_word_t                      exp_q [NQ][$];   // words still to be delivered
   bit                            cur_cut;
   int                            cur_prob;
   bit                            hold_rdy;
   int                            ld_rr;
   int                            err_cnt;
   int                            tests_run;
   int                            tests_failed;
   bit                            timed_out;

   // outputs as seen at the last falling edge
   hc_queue_mask_t                smp_wr;
   hc_queue_mask_t                smp_rdy;
   hc_queue_mask_t                smp_space;
   hc_queue_mask_t                smp_store;
   hc_entry_cnt_t [NQ-1:0]        smp_occ;

   dram_head_cache_top dram_head_cache_top_i (
      .clk                (clk),
      .reset              (reset),
      .store_wr           (store_wr),
      .store_queue        (store_queue),
      .store_entry        (store_entry),
      .store_space        (store_space),
      .tc_hc_wr           (tc_hc_wr),
      .tc_hc_entry        (tc_hc_entry),
      .hc_q_rdy           (hc_q_rdy),
      .mac_tx_rdy         (mac_tx_rdy),
      .hc_word            (hc_word),
      .hc_wr              (hc_wr),
      .hc_q_occup_cnt     (hc_q_occup_cnt),
      .hc_q_space_one_blk (hc_q_space_one_blk)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
                              input logic [CHK_W-1:0] actual);
      if (expected !== actual) begin
         $display("error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input string what, input int r);
      $display("timeout in row %0d: %s", r + 1, what);
      err_cnt++;
      timed_out = 1'b1;
   endtask

   function automatic hc_word_t random_word(input logic eop);
      hc_ctrl_t ctrl;
      hc_data_t data;
      data = {$urandom, $urandom};
      ctrl = eop ? hc_ctrl_t'($urandom_range(255, 1)) : '0;
      return {ctrl, data};
   endfunction

   // odd packets get a random padding word in the lower half
   task automatic add_packet(input int q, input int len);
      hc_word_t first;
      hc_word_t second;
      for (int n = 0; n < len; n += 2) begin
         first = random_word(n == len - 1);
         exp_q[q].push_back(first);
         if (n + 1 < len) begin
            second = random_word(n + 1 == len - 1);
            exp_q[q].push_back(second);
         end
         else begin
            second = random_word($urandom % 2 == 1);
         end
         ent_q[q].push_back({first, second});
      end
   endtask

   function automatic bit all_done(input bit words);
      for (int q = 0; q < NQ; q++) begin
         if (ent_q[q].size() != 0 || (words && exp_q[q].size() != 0))
            return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic bit occ_all(input hc_queue_mask_t mask, input int value);
      for (int q = 0; q < NQ; q++) begin
         if (mask[q] && smp_occ[q] != hc_entry_cnt_t'(value))
            return 1'b0;
      end
      return 1'b1;
   endfunction

   // ------------------------------------------------------------
   // one clock: sample and check, then drive the next inputs
   // ------------------------------------------------------------
   task automatic step_cycle();
      logic               nxt_wr;
      hc_queue_t          nxt_q;
      hc_entry_t          nxt_entry;
      hc_queue_mask_t     nxt_tc_wr;
      hc_entry_t [NQ-1:0] nxt_tc_entry;
      hc_queue_mask_t     nxt_rdy;
      int                 q;
      nxt_wr       = 1'b0;
      nxt_q        = '0;
      nxt_entry    = '0;
      nxt_tc_wr    = '0;
      nxt_tc_entry = '0;
      @(negedge clk);
      smp_wr    = hc_wr;
      smp_rdy   = hc_q_rdy;
      smp_space = hc_q_space_one_blk;
      smp_store = store_space;
      smp_occ   = hc_q_occup_cnt;
      for (int i = 0; i < NQ; i++) begin
         if (hc_wr[i]) begin
            if (exp_q[i].size() == 0) begin
               $display("unexpected word on queue %0d, nothing left to deliver", i);
               err_cnt++;
            end
            else begin
               check_value($sformatf("hc_word[%0d]", i), exp_q[i].pop_front(), hc_word[i]);
            end
         end
      end
      if (!cur_cut) begin
         for (int k = 0; k < NQ; k++) begin
            q = (ld_rr + k) % NQ;
            if (!nxt_wr && ent_q[q].size() != 0 && store_space[q]) begin
               nxt_wr    = 1'b1;
               nxt_q     = hc_queue_t'(q);
               nxt_entry = ent_q[q].pop_front();
               ld_rr     = (q + 1) % NQ;
            end
         end
      end
      else begin
         for (int i = 0; i < NQ; i++) begin
            // margin of one for the write still in flight
            if (ent_q[i].size() != 0 && hc_q_rdy[i] &&
                hc_q_occup_cnt[i] < `HC_QUEUE_DEPTH - 2) begin
               nxt_tc_wr[i]    = 1'b1;
               nxt_tc_entry[i] = ent_q[i].pop_front();
            end
         end
      end
      for (int i = 0; i < NQ; i++)
         nxt_rdy[i] = !hold_rdy && (($urandom % 100) < cur_prob);
      @(posedge clk);
      store_wr    <= nxt_wr;
      store_queue <= nxt_q;
      store_entry <= nxt_entry;
      tc_hc_wr    <= nxt_tc_wr;
      tc_hc_entry <= nxt_tc_entry;
      mac_tx_rdy  <= nxt_rdy;
   endtask

   // ------------------------------------------------------------
   // tests
   // ------------------------------------------------------------
   task automatic check_reset();
      int errs_before;
      errs_before = err_cnt;
      step_cycle();
      check_value("hc_wr", '0, smp_wr);
      check_value("hc_q_rdy", {NQ{1'b1}}, smp_rdy);
      check_value("hc_q_space_one_blk", {NQ{1'b1}}, smp_space);
      check_value("store_space", {NQ{1'b1}}, smp_store);
      for (int q = 0; q < NQ; q++)
         check_value($sformatf("hc_q_occup_cnt[%0d]", q), '0, smp_occ[q]);
      tests_run++;
      if (err_cnt != errs_before)
         tests_failed++;
      $display("test 0 reset values: %s", (err_cnt == errs_before) ? "ok" : "failed");
   endtask

   task automatic run_row(input int r);
      int cycles;
      int errs_before;
      errs_before = err_cnt;
      cur_cut  = rows[r].cut;
      cur_prob = rows[r].prob;
      hold_rdy = rows[r].hold;
      for (int q = 0; q < NQ; q++)
         for (int p = 0; p < MAX_PKTS; p++)
            if (rows[r].mask[q] && rows[r].lens[p] != 0)
               add_packet(q, rows[r].lens[p]);

      if (hold_rdy) begin
         cycles = 0;
         while (!(all_done(1'b0) && occ_all(rows[r].mask, SETTLE_CNT)) && !timed_out) begin
            step_cycle();
            cycles++;
            if (cycles >= LIMIT)
               report_timeout("head cache did not settle under back-pressure", r);
         end
         if (!timed_out) begin
            repeat (QUIET) begin
               step_cycle();                 // nothing may move in this window
               check_value("hc_wr", '0, smp_wr);
            end
            for (int q = 0; q < NQ; q++) begin
               if (rows[r].mask[q]) begin
                  check_value($sformatf("hc_q_occup_cnt[%0d]", q), SETTLE_CNT, smp_occ[q]);
                  check_value($sformatf("hc_q_space_one_blk[%0d]", q), 1'b0, smp_space[q]);
               end
            end
         end
         hold_rdy = 1'b0;
      end

      cycles = 0;
      while (!all_done(1'b1) && !timed_out) begin
         step_cycle();
         cycles++;
         if (cycles >= LIMIT)
            report_timeout("not all words were delivered", r);
      end

      // drop trailing padding so the next row starts empty
      cur_prob = 100;
      cycles   = 0;
      while (!occ_all({NQ{1'b1}}, 0) && !timed_out) begin
         step_cycle();
         cycles++;
         if (cycles >= LIMIT)
            report_timeout("queues did not drain", r);
      end

      tests_run++;
      if (err_cnt != errs_before)
         tests_failed++;
      $display("test %0d %s: %s", r + 1, rows[r].name,
               (err_cnt == errs_before) ? "ok" : "failed");
   endtask

   initial begin
      reset       = 1'b1;
      store_wr    = 1'b0;
      store_queue = '0;
      store_entry = '0;
      tc_hc_wr    = '0;
      tc_hc_entry = '0;
      mac_tx_rdy  = '0;
      void'($urandom(32'hfeb6831d));

      // name, mask, cut-through, packet lengths, rdy percent, hold
      rows[0] = '{"one queue odd and even", 4'b0001, 1'b0, '{3, 4, 1, 5, 0}, 100, 1'b0};
      rows[1] = '{"all queues at once", 4'b1111, 1'b0, '{5, 3, 6, 0, 0}, 100, 1'b0};
      rows[2] = '{"random back-pressure", 4'b1111, 1'b0, '{1, 8, 3, 9, 7}, 50, 1'b0};
      rows[3] = '{"cut-through", 4'b0110, 1'b1, '{3, 2, 5, 4, 0}, 70, 1'b0};
      rows[4] = '{"five blocks held back", 4'b1000, 1'b0, '{7, 9, 6, 8, 8}, 100, 1'b1};

      repeat (2) @(posedge clk);
      reset <= 1'b0;
      check_reset();
      for (int r = 0; r < NUM_ROWS; r++)
         if (!timed_out)
            run_row(r);

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/dram_head_cache_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module dram_head_cache_top
   import hc_data_pkg::*, hc_ctrl_pkg::*;
(
   input  logic                                clk,
   input  logic                                reset,

   // load port into the dram store
   input  logic                                store_wr,
   input  hc_queue_t                           store_queue,
   input  hc_entry_t                           store_entry,
   output hc_queue_mask_t                      store_space,

   // cut-through
   input  hc_queue_mask_t                      tc_hc_wr,
   input  hc_entry_t [`HC_NUM_QUEUES-1:0]      tc_hc_entry,
   output hc_queue_mask_t                      hc_q_rdy,

   // mac tx
   input  hc_queue_mask_t                      mac_tx_rdy,
   output hc_word_t [`HC_NUM_QUEUES-1:0]       hc_word,
   output hc_queue_mask_t                      hc_wr,

   // status
   output hc_entry_cnt_t [`HC_NUM_QUEUES-1:0]  hc_q_occup_cnt,
   output hc_queue_mask_t                      hc_q_space_one_blk
);

   hc_queue_t      hca_queue_num;
   logic           hca_queue_wr;
   hc_queue_mask_t blk_avail;
   logic           store_busy;
   logic           dram_wr;
   hc_entry_t      dram_entry;

   dram_block_store dram_block_store_i (
      .clk           (clk),
      .reset         (reset),
      .store_wr      (store_wr),
      .store_queue   (store_queue),
      .store_entry   (store_entry),
      .hca_queue_num (hca_queue_num),
      .hca_queue_wr  (hca_queue_wr),
      .store_space   (store_space),
      .blk_avail     (blk_avail),
      .store_busy    (store_busy),
      .dram_wr       (dram_wr),
      .dram_entry    (dram_entry)
   );

   hc_arbiter hc_arbiter_i (
      .clk                (clk),
      .reset              (reset),
      .hc_q_space_one_blk (hc_q_space_one_blk),
      .blk_avail          (blk_avail),
      .store_busy         (store_busy),
      .hca_queue_num      (hca_queue_num),
      .hca_queue_wr       (hca_queue_wr)
   );

   head_cache head_cache_i (
      .clk                (clk),
      .reset              (reset),
      .hca_queue_num      (hca_queue_num),
      .hca_queue_wr       (hca_queue_wr),
      .dram_entry         (dram_entry),
      .dram_wr            (dram_wr),
      .tc_hc_wr           (tc_hc_wr),
      .tc_hc_entry        (tc_hc_entry),
      .mac_tx_rdy         (mac_tx_rdy),
      .hc_q_occup_cnt     (hc_q_occup_cnt),
      .hc_q_space_one_blk (hc_q_space_one_blk),
      .hc_q_rdy           (hc_q_rdy),
      .hc_wr              (hc_wr),
      .hc_word            (hc_word)
   );

endmodule

`default_nettype wire

// File: hdl/dram_block_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module dram_block_store
   import hc_data_pkg::*, hc_ctrl_pkg::*;
(
   input  logic           clk,
   input  logic           reset,

   // load port
   input  logic           store_wr,
   input  hc_queue_t      store_queue,
   input  hc_entry_t      store_entry,

   // block request from the arbiter
   input  hc_queue_t      hca_queue_num,
   input  logic           hca_queue_wr,

   output hc_queue_mask_t store_space,
   output hc_queue_mask_t blk_avail,
   output logic           store_busy,
   output logic           dram_wr,
   output hc_entry_t      dram_entry
);

   localparam int BLOCK_ENTRIES = `HC_BLOCK_BYTES / `HC_ENTRY_BYTES;
   localparam int PTR_W         = $clog2(`HC_STORE_DEPTH);
   localparam int CNT_W         = $clog2(`HC_STORE_DEPTH + 1);
   localparam int BEAT_W        = $clog2(BLOCK_ENTRIES);

   // one ring per queue, addressed {queue, pointer}
   hc_entry_t         mem [`HC_NUM_QUEUES * `HC_STORE_DEPTH];
   logic [PTR_W-1:0]  wr_ptr [`HC_NUM_QUEUES];
   logic [PTR_W-1:0]  rd_ptr [`HC_NUM_QUEUES];
   logic [CNT_W-1:0]  cnt    [`HC_NUM_QUEUES];

   hc_store_state_t   state;
   hc_queue_t         burst_q;
   logic [BEAT_W-1:0] beat;
   logic              load;
   hc_queue_mask_t    inc_q;
   hc_queue_mask_t    dec_q;

   for (genvar q = 0; q < `HC_NUM_QUEUES; q++) begin : g_flags
      assign store_space[q] = (cnt[q] != CNT_W'(`HC_STORE_DEPTH));
      assign blk_avail[q]   = (cnt[q] >= CNT_W'(BLOCK_ENTRIES));
   end

   assign load  = store_wr & store_space[store_queue];
   assign inc_q = load ? (hc_queue_mask_t'(1) << store_queue) : '0;
   assign dec_q = dram_wr ? (hc_queue_mask_t'(1) << burst_q) : '0;

   assign dram_wr    = (state == STORE_BURST);
   assign dram_entry = mem[{burst_q, rd_ptr[burst_q]}];
   assign store_busy = hca_queue_wr | dram_wr;    // from grant to last entry

   // ------------------------------------------------------------
   // memory and per-queue rings
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (load)
         mem[{store_queue, wr_ptr[store_queue]}] <= store_entry;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int q = 0; q < `HC_NUM_QUEUES; q++) begin
            wr_ptr[q] <= '0;
            rd_ptr[q] <= '0;
            cnt[q]    <= '0;
         end
      end
      else begin
         for (int q = 0; q < `HC_NUM_QUEUES; q++) begin
            if (inc_q[q])
               wr_ptr[q] <= wr_ptr[q] + 1'b1;
            if (dec_q[q])
               rd_ptr[q] <= rd_ptr[q] + 1'b1;
            case ({inc_q[q], dec_q[q]})
               2'b10:   cnt[q] <= cnt[q] + 1'b1;
               2'b01:   cnt[q] <= cnt[q] - 1'b1;
               default: cnt[q] <= cnt[q];
            endcase
         end
      end
   end

   // ------------------------------------------------------------
   // burst machine, one block per grant
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= STORE_IDLE;
         burst_q <= '0;
         beat    <= '0;
      end
      else begin
         case (state)
            STORE_IDLE: begin
               if (hca_queue_wr) begin
                  burst_q <= hca_queue_num;
                  beat    <= '0;
                  state   <= STORE_BURST;
               end
            end

            STORE_BURST: begin
               beat <= beat + 1'b1;
               if (beat == BEAT_W'(BLOCK_ENTRIES - 1))
                  state <= STORE_IDLE;     // last entry out this cycle
            end

            default: state <= STORE_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/hc_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module hc_arbiter
   import hc_ctrl_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   input  hc_queue_mask_t hc_q_space_one_blk,
   input  hc_queue_mask_t blk_avail,
   input  logic           store_busy,
   output hc_queue_t      hca_queue_num,     // also the last queue granted
   output logic           hca_queue_wr
);

   hc_arb_state_t  state;
   hc_queue_mask_t eligible;
   hc_queue_t      cand;
   hc_queue_t      pick;
   logic           found;

   // room in the head cache and a full block waiting in dram
   assign eligible = hc_q_space_one_blk & blk_avail;

   // ------------------------------------------------------------
   // round robin, search starts after the last grant
   // ------------------------------------------------------------
   always_comb begin
      found = 1'b0;
      pick  = hca_queue_num;
      cand  = hca_queue_num;
      for (int k = 1; k <= `HC_NUM_QUEUES; k++) begin
         cand = hc_queue_t'((int'(hca_queue_num) + k) % `HC_NUM_QUEUES);
         if (!found && eligible[cand]) begin
            found = 1'b1;
            pick  = cand;
         end
      end
   end

   // ------------------------------------------------------------
   // grant pulse, then hold off until the burst is over
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= ARB_SCAN;
         hca_queue_wr  <= 1'b0;
         hca_queue_num <= hc_queue_t'(`HC_NUM_QUEUES - 1);  // queue 0 served first
      end
      else begin
         hca_queue_wr <= 1'b0;

         case (state)
            ARB_SCAN: begin
               if (found && !store_busy) begin
                  hca_queue_wr  <= 1'b1;
                  hca_queue_num <= pick;
                  state         <= ARB_WAIT;
               end
            end

            ARB_WAIT: begin
               if (!store_busy)
                  state <= ARB_SCAN;        // counts settled by now
            end

            default: state <= ARB_SCAN;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/head_cache.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module head_cache
   import hc_data_pkg::*, hc_ctrl_pkg::*;
(
   input  logic                                clk,
   input  logic                                reset,

   // grant from the arbiter and the dram burst
   input  hc_queue_t                           hca_queue_num,
   input  logic                                hca_queue_wr,
   input  hc_entry_t                           dram_entry,
   input  logic                                dram_wr,

   // cut-through from the tail cache
   input  hc_queue_mask_t                      tc_hc_wr,
   input  hc_entry_t [`HC_NUM_QUEUES-1:0]      tc_hc_entry,

   // mac tx side
   input  hc_queue_mask_t                      mac_tx_rdy,

   output hc_entry_cnt_t [`HC_NUM_QUEUES-1:0]  hc_q_occup_cnt,
   output hc_queue_mask_t                      hc_q_space_one_blk,
   output hc_queue_mask_t                      hc_q_rdy,
   output hc_queue_mask_t                      hc_wr,
   output hc_word_t [`HC_NUM_QUEUES-1:0]       hc_word
);

   localparam int BLOCK_ENTRIES = `HC_BLOCK_BYTES / `HC_ENTRY_BYTES;

   hc_inp_state_t                      inp_state;
   hc_queue_mask_t                     dram_target;    // one-hot, queue fed by dram
   hc_byte_cnt_t                       byte_cnt;
   hc_byte_cnt_t                       byte_nxt;

   hc_entry_t [`HC_NUM_QUEUES-1:0]     oq_din;
   hc_queue_mask_t                     wr_oq;
   hc_queue_mask_t                     rd_oq;
   hc_queue_mask_t                     empty_oq;
   hc_queue_mask_t                     almost_full_oq;
   hc_queue_mask_t                     word_valid_oq;

   // ------------------------------------------------------------
   // per-queue fifos
   // ------------------------------------------------------------
   for (genvar i = 0; i < `HC_NUM_QUEUES; i++) begin : g_queue
      assign oq_din[i] = dram_target[i] ? dram_entry : tc_hc_entry[i];

      // free entries must exceed one block
      assign hc_q_space_one_blk[i] =
         (`HC_QUEUE_DEPTH - hc_q_occup_cnt[i]) > BLOCK_ENTRIES;

      head_cache_queue queue_i (
         .clk         (clk),
         .reset       (reset),
         .wr          (wr_oq[i]),
         .din         (oq_din[i]),
         .rd          (rd_oq[i]),
         .dout        (hc_word[i]),
         .empty       (empty_oq[i]),
         .word_valid  (word_valid_oq[i]),
         .almost_full (almost_full_oq[i]),
         .occup_cnt   (hc_q_occup_cnt[i])
      );
   end

   // dram target takes the burst, every other queue takes cut-through
   assign wr_oq = ~almost_full_oq &
                  ((dram_target & {`HC_NUM_QUEUES{dram_wr}}) | (~dram_target & tc_hc_wr));

   assign hc_q_rdy = ~almost_full_oq & ~dram_target;

   assign rd_oq = ~empty_oq & mac_tx_rdy;
   assign hc_wr = rd_oq & word_valid_oq;     // padding consumed silently

   // ------------------------------------------------------------
   // input machine, tracks one dram block
   // ------------------------------------------------------------
   assign byte_nxt = byte_cnt + hc_byte_cnt_t'(`HC_ENTRY_BYTES);

   always_ff @(posedge clk) begin
      if (reset) begin
         inp_state   <= INP_IDLE;
         dram_target <= '0;
         byte_cnt    <= '0;
      end
      else begin
         case (inp_state)
            INP_IDLE: begin
               if (hca_queue_wr) begin
                  dram_target <= hc_queue_mask_t'(1) << hca_queue_num;
                  byte_cnt    <= '0;
                  inp_state   <= INP_TRANSFER;
               end
            end

            INP_TRANSFER: begin
               if (dram_wr) begin
                  byte_cnt <= byte_nxt;
                  if (byte_nxt == hc_byte_cnt_t'(`HC_BLOCK_BYTES)) begin
                     dram_target <= '0;       // block done
                     inp_state   <= INP_IDLE;
                  end
               end
            end

            default: inp_state <= INP_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/head_cache_queue.sv
`default_nettype none
`timescale 1ns/1ps

`include "hc_settings.svh"

module head_cache_queue
   import hc_data_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          wr,
   input  hc_entry_t     din,
   input  logic          rd,
   output hc_word_t      dout,
   output logic          empty,
   output logic          word_valid,
   output logic          almost_full,
   output hc_entry_cnt_t occup_cnt
);

   localparam int PTR_W = $clog2(`HC_QUEUE_DEPTH);

   hc_entry_t        mem [`HC_QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             half;          // 0 upper word, 1 lower word
   hc_word_t         first_word;
   hc_word_t         second_word;
   hc_ctrl_t         first_ctrl;
   logic             pad_half;
   logic             pop_word;
   logic             pop_entry;

   // ------------------------------------------------------------
   // show-ahead read side
   // ------------------------------------------------------------
   assign {first_word, second_word} = mem[rd_ptr];
   assign first_ctrl = first_word[$bits(hc_word_t)-1 -: `HC_CTRL_WIDTH];

   // lower half after an eop upper half is the padding word
   assign pad_half = half & (|first_ctrl);

   assign dout        = half ? second_word : first_word;
   assign empty       = (occup_cnt == '0);
   assign word_valid  = ~empty & ~pad_half;
   assign almost_full = (occup_cnt >= hc_entry_cnt_t'(`HC_QUEUE_DEPTH - 1));

   assign pop_word  = rd & ~empty;
   assign pop_entry = pop_word & half;     // entry leaves after its lower half

   // ------------------------------------------------------------
   // storage
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_ptr] <= din;
   end

   // ------------------------------------------------------------
   // pointers and occupancy
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         half      <= 1'b0;
         occup_cnt <= '0;
      end
      else begin
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;

         if (pop_word) begin
            half <= ~half;
            if (half)
               rd_ptr <= rd_ptr + 1'b1;   // next entry, upper word first
         end

         case ({wr, pop_entry})
            2'b10:   occup_cnt <= occup_cnt + 1'b1;
            2'b01:   occup_cnt <= occup_cnt - 1'b1;
            default: occup_cnt <= occup_cnt;     // none, or in and out together
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/hc_ctrl_pkg.sv
`default_nettype none

`include "hc_settings.svh"

package hc_ctrl_pkg;

   // ------------------------------------------------------------
   // queue addressing
   // ------------------------------------------------------------
   typedef logic [$clog2(`HC_NUM_QUEUES)-1:0] hc_queue_t;
   typedef logic [`HC_NUM_QUEUES-1:0]         hc_queue_mask_t;   // bit per queue

   // ------------------------------------------------------------
   // state machines
   // ------------------------------------------------------------
   // head cache input side
   typedef enum logic {
      INP_IDLE,
      INP_TRANSFER
   } hc_inp_state_t;

   typedef enum logic {
      ARB_SCAN,     // looking for a queue to serve
      ARB_WAIT      // burst in flight
   } hc_arb_state_t;

   typedef enum logic {
      STORE_IDLE,
      STORE_BURST
   } hc_store_state_t;

endpackage

`default_nettype wire

// File: hdl/hc_data_pkg.sv
`default_nettype none

`include "hc_settings.svh"

package hc_data_pkg;

   // ------------------------------------------------------------
   // word and entry layout
   // ------------------------------------------------------------
   typedef logic [`HC_DATA_WIDTH-1:0] hc_data_t;
   typedef logic [`HC_CTRL_WIDTH-1:0] hc_ctrl_t;

   // control field sits above the data
   typedef logic [`HC_CTRL_WIDTH+`HC_DATA_WIDTH-1:0] hc_word_t;

   // first word of the entry in the upper half
   typedef logic [2*(`HC_CTRL_WIDTH+`HC_DATA_WIDTH)-1:0] hc_entry_t;

   // ------------------------------------------------------------
   // counters
   // ------------------------------------------------------------
   typedef logic [$clog2(`HC_QUEUE_DEPTH+1)-1:0] hc_entry_cnt_t;  // 0 .. full depth
   typedef logic [$clog2(`HC_BLOCK_BYTES+1)-1:0] hc_byte_cnt_t;   // bytes of one burst

endpackage

`default_nettype wire

// File: hdl/hc_settings.svh
`ifndef HC_SETTINGS_SVH
`define HC_SETTINGS_SVH

// ------------------------------------------------------------
// queue and data path sizes
// ------------------------------------------------------------
`define HC_NUM_QUEUES   4       // output queues
`define HC_DATA_WIDTH   64      // data field of one word
`define HC_CTRL_WIDTH   8       // control field, nonzero marks eop

// ------------------------------------------------------------
// buffering
// ------------------------------------------------------------
`define HC_QUEUE_DEPTH  16      // entries per head-cache fifo
`define HC_BLOCK_BYTES  72      // one dram transfer
`define HC_ENTRY_BYTES  18      // two 72-bit words
`define HC_STORE_DEPTH  32      // entries per queue in dram

`endif
